/* source/aes_pkg.sv */
// shared types and byte helpers for the AES-256 encryption core
package aes_pkg;

    // one 128-bit state or data block, first byte in the top bits
    typedef logic [127:0] block_t;

    // 256-bit cipher key, eight schedule words
    typedef logic [255:0] key_t;

    // single key schedule word
    typedef logic [31:0] word_t;

    // payload of the input stream
    typedef struct packed {
        key_t   key;
        block_t plaintext;
    } aes_job_t;

    // AES-256 round count
    localparam int unsigned NUM_ROUNDS = 14;

    // forward S-box, element 0 sits in the top byte
    // each row below holds sixteen consecutive entries
    localparam logic [0:255][7:0] SBOX_TABLE = {
        128'h637c777bf26b6fc53001672bfed7ab76,
        128'hca82c97dfa5947f0add4a2af9ca472c0,
        128'hb7fd9326363ff7cc34a5e5f171d83115,
        128'h04c723c31896059a071280e2eb27b275,
        128'h09832c1a1b6e5aa0523bd6b329e32f84,
        128'h53d100ed20fcb15b6acbbe394a4c58cf,
        128'hd0efaafb434d338545f9027f503c9fa8,
        128'h51a3408f929d38f5bcb6da2110fff3d2,
        128'hcd0c13ec5f974417c4a77e3d645d1973,
        128'h60814fdc222a908846eeb814de5e0bdb,
        128'he0323a0a4906245cc2d3ac629195e479,
        128'he7c8376d8dd54ea96c56f4ea657aae08,
        128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
        128'h703eb5664803f60e613557b986c11d9e,
        128'he1f8981169d98e949b1e87e9ce5528df,
        128'h8ca1890dbfe6426841992d0fb054bb16
    };

    // byte substitution through the table
    function automatic logic [7:0] sbox(input logic [7:0] b);
        return SBOX_TABLE[b];
    endfunction

    // multiply by x in GF(2^8)
    // reduction polynomial x^8 + x^4 + x^3 + x + 1
    function automatic logic [7:0] xtime(input logic [7:0] b);
        logic [7:0] shifted;
        shifted = {b[6:0], 1'b0};
        // fold the carried-out bit back in
        if (b[7]) begin
            shifted = shifted ^ 8'h1b;
        end
        return shifted;
    endfunction

endpackage

/* source/key_sched_if.sv */
`timescale 1ns/1ps

// link between round engine and key schedule
interface key_sched_if;

    // capture a new cipher key
    logic           load;
    logic [255:0]   key;
    // advance to the next round key
    logic           step;
    // current round key, upper half of the window
    logic [127:0]   round_key;

    // engine side drives the controls
    modport engine (output load, output key, output step, input round_key);

    // schedule side answers with the round key
    modport schedule (input load, input key, input step, output round_key);

endinterface

/* source/aes_skid_buffer.sv */
`timescale 1ns/1ps

// two-entry valid/ready buffer
// in_ready comes straight from a flop
module aes_skid_buffer #(
    parameter type payload_t = aes_pkg::block_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // skid entry holds one item while the output stalls
    logic     skid_valid;
    payload_t skid_data;
    logic     push;
    logic     advance;

    // room as long as the skid entry is empty
    assign in_ready = !skid_valid;
    assign push     = in_valid && in_ready;
    // main entry can take a new item
    assign advance  = out_ready || !out_valid;

    // occupancy flags
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (advance) begin
            // skid drains first to keep order
            out_valid  <= skid_valid || push;
            skid_valid <= 1'b0;
        end else if (push) begin
            skid_valid <= 1'b1;
        end
    end

    // payload, written only on a move
    always_ff @(posedge clk) begin
        if (advance && skid_valid) begin
            out_data <= skid_data;
        end else if (advance && push) begin
            out_data <= in_data;
        end else if (!advance && push) begin
            skid_data <= in_data;
        end
    end

endmodule

/* source/aes_key_schedule.sv */
`timescale 1ns/1ps

// AES-256 key expansion, one round key per step
// window holds eight words, the oldest at index 0
module aes_key_schedule (
    input logic         clk,
    input logic         rst,
    key_sched_if.schedule key_port
);

    aes_pkg::word_t [0:7] win;
    aes_pkg::word_t [0:3] fresh;
    aes_pkg::word_t       mixer;
    // round constant and odd/even step tracker
    logic [7:0]           rcon;
    logic                 odd_step;

    // S-box on each byte of a word
    function automatic aes_pkg::word_t sub_word(input aes_pkg::word_t w);
        return {aes_pkg::sbox(w[31:24]), aes_pkg::sbox(w[23:16]),
                aes_pkg::sbox(w[15:8]), aes_pkg::sbox(w[7:0])};
    endfunction

    // next four words from the current window
    always_comb begin
        if (odd_step) begin
            // word index multiple of eight, RotWord first
            mixer = sub_word({win[7][23:0], win[7][31:24]}) ^ {rcon, 24'h0};
        end else begin
            // index four past a multiple of eight
            mixer = sub_word(win[7]);
        end
        fresh[0] = win[0] ^ mixer;
        for (int i = 1; i < 4; i++) begin
            fresh[i] = win[i] ^ fresh[i - 1];
        end
    end

    // step control
    always_ff @(posedge clk) begin
        if (rst || key_port.load) begin
            rcon     <= 8'h01;
            odd_step <= 1'b1;
        end else if (key_port.step) begin
            // constant doubles after each odd step
            if (odd_step) begin
                rcon <= aes_pkg::xtime(rcon);
            end
            odd_step <= !odd_step;
        end
    end

    // window slides by four words per step
    always_ff @(posedge clk) begin
        if (key_port.load) begin
            win <= key_port.key;
        end else if (key_port.step) begin
            win <= {win[4:7], fresh};
        end
    end

    assign key_port.round_key = win[0:3];

endmodule

/* source/aes_round_logic.sv */
`timescale 1ns/1ps

// one combinational AES round
// byte 0 of the block is row 0 column 0
module aes_round_logic (
    input  aes_pkg::block_t state_in,
    input  aes_pkg::block_t round_key,
    input  logic            last_round,
    output aes_pkg::block_t state_out
);

    logic [0:15][7:0] in_b;
    logic [0:15][7:0] sub_b;
    logic [0:15][7:0] shift_b;
    logic [0:15][7:0] mix_b;

    // MixColumns on a single column
    function automatic logic [31:0] mix_column(input logic [31:0] col);
        logic [7:0] a0, a1, a2, a3;
        a0 = col[31:24];
        a1 = col[23:16];
        a2 = col[15:8];
        a3 = col[7:0];
        return {aes_pkg::xtime(a0 ^ a1) ^ a1 ^ a2 ^ a3,
                aes_pkg::xtime(a1 ^ a2) ^ a2 ^ a3 ^ a0,
                aes_pkg::xtime(a2 ^ a3) ^ a3 ^ a0 ^ a1,
                aes_pkg::xtime(a3 ^ a0) ^ a0 ^ a1 ^ a2};
    endfunction

    assign in_b = state_in;

    always_comb begin
        // SubBytes
        for (int i = 0; i < 16; i++) begin
            sub_b[i] = aes_pkg::sbox(in_b[i]);
        end
        // ShiftRows, row r rotates left by r
        for (int c = 0; c < 4; c++) begin
            for (int r = 0; r < 4; r++) begin
                shift_b[r + 4 * c] = sub_b[r + 4 * ((c + r) % 4)];
            end
        end
        // MixColumns, four bytes per column
        for (int c = 0; c < 4; c++) begin
            mix_b[4 * c +: 4] = mix_column(shift_b[4 * c +: 4]);
        end
    end

    // final round skips MixColumns
    assign state_out = (last_round ? shift_b : mix_b) ^ round_key;

endmodule

/* source/aes_round_engine.sv */
`timescale 1ns/1ps

// iterative round engine, one round per cycle
// first running cycle only steps the schedule to round key 1
module aes_round_engine (
    input  logic               clk,
    input  logic               rst,
    input  logic               job_valid,
    output logic               job_ready,
    input  aes_pkg::aes_job_t  job,
    key_sched_if.engine        key_port,
    output logic               result_valid,
    input  logic               result_ready,
    output aes_pkg::block_t    result
);

    localparam int CNT_W = $clog2(aes_pkg::NUM_ROUNDS + 1);

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_RUN,
        PH_DONE
    } phase_t;

    phase_t           phase;
    // rounds already applied to the state
    logic [CNT_W-1:0] round_cnt;
    aes_pkg::block_t  state_q;
    aes_pkg::block_t  round_out;
    logic             accept;
    logic             last_round;

    assign job_ready  = (phase == PH_IDLE);
    assign accept     = job_valid && job_ready;
    // round 14 is computed while the counter reads 14
    assign last_round = (round_cnt == CNT_W'(aes_pkg::NUM_ROUNDS));

    // schedule loads with the job, then steps once per round
    assign key_port.load = accept;
    assign key_port.key  = job.key;
    assign key_port.step = (phase == PH_RUN) && !last_round;

    aes_round_logic i_round_logic (
        .state_in   (state_q),
        .round_key  (key_port.round_key),
        .last_round (last_round),
        .state_out  (round_out)
    );

    // phase and round counter
    always_ff @(posedge clk) begin
        if (rst) begin
            phase     <= PH_IDLE;
            round_cnt <= '0;
        end else begin
            case (phase)
                PH_IDLE: begin
                    if (accept) begin
                        phase     <= PH_RUN;
                        round_cnt <= '0;
                    end
                end
                PH_RUN: begin
                    if (last_round) begin
                        phase <= PH_DONE;
                    end else begin
                        round_cnt <= round_cnt + 1'b1;
                    end
                end
                PH_DONE: begin
                    // back to idle on the output transfer
                    if (result_ready) begin
                        phase <= PH_IDLE;
                    end
                end
                default: begin
                    phase <= PH_IDLE;
                end
            endcase
        end
    end

    // state register, initial AddRoundKey with the key's upper half
    always_ff @(posedge clk) begin
        if (accept) begin
            state_q <= job.plaintext ^ job.key[255:128];
        end else if (phase == PH_RUN && round_cnt != '0) begin
            state_q <= round_out;
        end
    end

    // result held until taken
    assign result_valid = (phase == PH_DONE);
    assign result       = state_q;

endmodule

/* source/aes_encrypt_top.sv */
`timescale 1ns/1ps

// AES-256 encryption core top level
// job skid buffer, round engine with key schedule, ciphertext skid buffer
module aes_encrypt_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    output logic            in_ready,
    input  aes_pkg::key_t   key,
    input  aes_pkg::block_t plaintext,
    output logic            out_valid,
    input  logic            out_ready,
    output aes_pkg::block_t ciphertext
);

    // input side to engine
    aes_pkg::aes_job_t job_in;
    aes_pkg::aes_job_t job;
    logic              job_valid;
    logic              job_ready;

    // engine to output side
    aes_pkg::block_t   result;
    logic              result_valid;
    logic              result_ready;

    key_sched_if key_bus ();

    // key and plaintext travel as one job
    assign job_in.key       = key;
    assign job_in.plaintext = plaintext;

    aes_skid_buffer #(
        .payload_t (aes_pkg::aes_job_t)
    ) in_buffer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (job_in),
        .out_valid (job_valid),
        .out_ready (job_ready),
        .out_data  (job)
    );

    aes_round_engine i_round_engine (
        .clk          (clk),
        .rst          (rst),
        .job_valid    (job_valid),
        .job_ready    (job_ready),
        .job          (job),
        .key_port     (key_bus.engine),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result       (result)
    );

    aes_key_schedule i_key_schedule (
        .clk      (clk),
        .rst      (rst),
        .key_port (key_bus.schedule)
    );

    aes_skid_buffer #(
        .payload_t (aes_pkg::block_t)
    ) out_buffer (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (result_valid),
        .in_ready  (result_ready),
        .in_data   (result),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (ciphertext)
    );

endmodule

/* sim/aes_model.svh */
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// Galois LFSR, x^32 + x^22 + x^2 + x + 1, right shifting
// caller takes bit 0 after each step
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 32'h80200003;
    end
    return n;
endfunction

// shift-and-add product in GF(2^8)
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = 8'h00;
    x = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            p = p ^ x;
        end
        // next power of x, reduced by 0x11b
        x = x[7] ? ({x[6:0], 1'b0} ^ 8'h1b) : {x[6:0], 1'b0};
    end
    return p;
endfunction

// S-box on all four bytes of a word
function automatic logic [31:0] subst_word(input logic [31:0] w);
    return {aes_pkg::sbox(w[31:24]), aes_pkg::sbox(w[23:16]),
            aes_pkg::sbox(w[15:8]), aes_pkg::sbox(w[7:0])};
endfunction

// reference AES-256 encryption of one block
// state byte i sits at column i/4, row i%4
function automatic logic [127:0] aes256_encrypt(input logic [255:0] k, input logic [127:0] pt);
    logic [31:0]  w [0:59];
    logic [31:0]  t;
    logic [7:0]   rc;
    logic [7:0]   s [0:15];
    logic [7:0]   u [0:15];
    logic [7:0]   a0, a1, a2, a3;
    logic [127:0] res;
    // full key expansion up front, 60 words
    rc = 8'h01;
    for (int i = 0; i < 8; i++) begin
        w[i] = k[255 - 32 * i -: 32];
    end
    for (int i = 8; i < 60; i++) begin
        t = w[i - 1];
        if (i % 8 == 0) begin
            t = subst_word({t[23:0], t[31:24]}) ^ {rc, 24'h0};
            rc = gf_mul(rc, 8'h02);
        end else if (i % 8 == 4) begin
            t = subst_word(t);
        end
        w[i] = w[i - 8] ^ t;
    end
    // initial AddRoundKey
    for (int i = 0; i < 16; i++) begin
        s[i] = pt[127 - 8 * i -: 8] ^ w[i / 4][31 - 8 * (i % 4) -: 8];
    end
    for (int r = 1; r <= 14; r++) begin
        for (int i = 0; i < 16; i++) begin
            u[i] = aes_pkg::sbox(s[i]);
        end
        // row shifts left by its index
        for (int c = 0; c < 4; c++) begin
            for (int row = 0; row < 4; row++) begin
                s[row + 4 * c] = u[row + 4 * ((c + row) % 4)];
            end
        end
        // no column mixing in the last round
        if (r < 14) begin
            for (int c = 0; c < 4; c++) begin
                a0 = s[4 * c];
                a1 = s[4 * c + 1];
                a2 = s[4 * c + 2];
                a3 = s[4 * c + 3];
                s[4 * c]     = gf_mul(a0, 8'h02) ^ gf_mul(a1, 8'h03) ^ a2 ^ a3;
                s[4 * c + 1] = a0 ^ gf_mul(a1, 8'h02) ^ gf_mul(a2, 8'h03) ^ a3;
                s[4 * c + 2] = a0 ^ a1 ^ gf_mul(a2, 8'h02) ^ gf_mul(a3, 8'h03);
                s[4 * c + 3] = gf_mul(a0, 8'h03) ^ a1 ^ a2 ^ gf_mul(a3, 8'h02);
            end
        end
        for (int i = 0; i < 16; i++) begin
            s[i] = s[i] ^ w[4 * r + i / 4][31 - 8 * (i % 4) -: 8];
        end
    end
    for (int i = 0; i < 16; i++) begin
        res[127 - 8 * i -: 8] = s[i];
    end
    return res;
endfunction

`endif

/* sim/aes_tb.sv */
`timescale 1ns/1ps

// testbench for the AES-256 encryption core
module aes_tb;

    localparam int WAIT_LIMIT    = 400;
    localparam int DRAIN_LIMIT   = 3000;
    localparam int FIRST_LATENCY = 17;
    localparam logic [127:0] FIPS_CT = 128'h8ea2b7ca516745bfeafc49904b496089;

    logic            clk;
    logic            rst;
    logic            in_valid;
    logic            in_ready;
    aes_pkg::key_t   key;
    aes_pkg::block_t plaintext;
    logic            out_valid;
    logic            out_ready = 1'b1;
    aes_pkg::block_t ciphertext;

    // expected ciphertexts, oldest first
    aes_pkg::block_t exp_q[$];
    int              errors   = 0;
    int              checks   = 0;
    int              issued   = 0;
    int              received = 0;
    // stimulus generator and output stall generator
    logic [31:0]     rng      = 32'h8995;
    logic [31:0]     bp_rng   = 32'h8995;
    logic            bp_mode  = 1'b0;
    // output seen stalled on the last edge
    logic            held_valid = 1'b0;
    aes_pkg::block_t held_data;

    `include "aes_model.svh"

    aes_encrypt_top i_aes_encrypt_top (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .key        (key),
        .plaintext  (plaintext),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .ciphertext (ciphertext)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // n fresh bits, one LFSR step each
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rng = lfsr_next(rng);
            v = {v[30:0], rng[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("error %s: got %h, expected %h", name, actual, expected);
            errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        errors++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
        end
    endtask

    // called on a falling edge, returns on the falling edge after the transfer
    task automatic issue_job(input aes_pkg::key_t k, input aes_pkg::block_t p,
                             input aes_pkg::block_t ct);
        int waited;
        waited = 0;
        in_valid  = 1'b1;
        key       = k;
        plaintext = p;
        // in_ready is a flop, steady at the falling edge
        while (!in_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (in_ready) begin
            @(negedge clk);
            exp_q.push_back(ct);
            issued++;
        end else begin
            report_timeout("in_ready stayed low while a job was offered");
        end
        in_valid = 1'b0;
    endtask

    task automatic issue_random();
        aes_pkg::key_t   k;
        aes_pkg::block_t p;
        for (int i = 0; i < 8; i++) begin
            k = {k[223:0], take_bits(32)};
        end
        for (int i = 0; i < 4; i++) begin
            p = {p[95:0], take_bits(32)};
        end
        issue_job(k, p, aes256_encrypt(k, p));
    endtask

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!in_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            report_timeout("in_ready did not rise after reset");
        end
    endtask

    // all outstanding ciphertexts taken
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            report_timeout("ciphertexts still missing from the output");
        end
    endtask

    // random out_ready only in back-pressure phases
    always @(negedge clk) begin
        if (bp_mode) begin
            bp_rng = lfsr_next(bp_rng);
            out_ready = bp_rng[0];
        end else begin
            out_ready = 1'b1;
        end
    end

    // scoreboard on the output stream, pre-edge values
    always @(posedge clk) begin
        if (rst) begin
            held_valid = 1'b0;
        end else begin
            // stalled output must hold
            if (held_valid) begin
                check_value("out_valid", out_valid, 1'b1);
                check_value("ciphertext", ciphertext, held_data);
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("output transfer with no job outstanding");
                    errors++;
                end else begin
                    check_value("ciphertext", ciphertext, exp_q.pop_front());
                end
                received++;
            end
            held_valid = out_valid && !out_ready;
            held_data  = ciphertext;
        end
    end

    initial begin
        aes_pkg::key_t   fips_key;
        aes_pkg::block_t fips_pt;
        int              lat;
        rst       = 1'b1;
        in_valid  = 1'b0;
        key       = '0;
        plaintext = '0;
        fips_key  = 256'h000102030405060708090a0b0c0d0e0f101112131415161718191a1b1c1d1e1f;
        fips_pt   = 128'h00112233445566778899aabbccddeeff;
        repeat (5) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst = 1'b0;
        // state right after reset
        check_value("out_valid", out_valid, 1'b0);
        wait_ready();
        // FIPS-197 vector, model first
        check_value("model_ciphertext", aes256_encrypt(fips_key, fips_pt), FIPS_CT);
        issue_job(fips_key, fips_pt, FIPS_CT);
        wait_drain();
        // first random job on an idle core, latency counted in falling edges
        issue_random();
        lat = 0;
        while (!out_valid && lat < WAIT_LIMIT) begin
            @(negedge clk);
            lat++;
        end
        if (!out_valid) begin
            report_timeout("no ciphertext for the first random job");
        end
        check_value("latency", lat, FIRST_LATENCY);
        for (int i = 1; i < 40; i++) begin
            issue_random();
            idle_cycles(take_bits(3));
        end
        wait_drain();
        // mode switch away from the driving edge
        @(posedge clk);
        bp_mode = 1'b1;
        @(negedge clk);
        for (int i = 0; i < 24; i++) begin
            issue_random();
            idle_cycles(take_bits(2));
        end
        // burst, in_valid stays high between jobs
        for (int i = 0; i < 12; i++) begin
            issue_random();
        end
        wait_drain();
        @(posedge clk);
        bp_mode = 1'b0;
        @(negedge clk);
        check_value("result_count", received, issued);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+sim
source/aes_pkg.sv
source/key_sched_if.sv
source/aes_skid_buffer.sv
source/aes_key_schedule.sv
source/aes_round_logic.sv
source/aes_round_engine.sv
source/aes_encrypt_top.sv
sim/aes_tb.sv

/* Bender.yml */
package:
  name: aes_encrypt

sources:
  - source/aes_pkg.sv
  - source/key_sched_if.sv
  - source/aes_skid_buffer.sv
  - source/aes_key_schedule.sv
  - source/aes_round_logic.sv
  - source/aes_round_engine.sv
  - source/aes_encrypt_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/aes_tb.sv
